/* hdl/filter_fsm.sv */
// filter controller: debounces pulse and boost levels and registers sigout and boost
`timescale 1ns/1ps

module filter_fsm #(
   parameter int CNT_W             = 8,
   parameter int DEBOUNCE_HI_CNT   = 8,
   parameter int DEBOUNCE_LO_CNT   = 8,
   parameter int MIN_HI_CNT        = 16,
   parameter bit RESTART_HI_PERIOD = 1'b0
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  filter_pkg::sync_in_t    sync,
   input  logic                    cnt_zero,
   output filter_pkg::timer_ctrl_t tctl,
   output logic [CNT_W-1:0]        load_val,
   output filter_pkg::filter_out_t out
);
   import filter_pkg::*;

   // period lengths sized to the timer
   localparam logic [CNT_W-1:0] LD_DEB_HI = CNT_W'(DEBOUNCE_HI_CNT);
   localparam logic [CNT_W-1:0] LD_DEB_LO = CNT_W'(DEBOUNCE_LO_CNT);
   localparam logic [CNT_W-1:0] LD_MIN_HI = CNT_W'(MIN_HI_CNT);

   filter_state_t state;
   filter_state_t state_nxt;
   filter_out_t   out_nxt;

   // state and both outputs change together on the clock edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= low;
         out   <= '0;
      end
      else begin
         state <= state_nxt;
         out   <= out_nxt;
      end
   end

   always_comb begin
      // defaults: timer cleared, outputs and state held
      tctl      = '0;
      load_val  = LD_DEB_HI;
      state_nxt = state;
      out_nxt   = out;

      case (state)
         low: begin
            out_nxt = '0;
            // first high sample starts the high debounce
            if (sync.pulse) begin
               tctl.en   = 1'b1;
               tctl.ld   = 1'b1;
               load_val  = LD_DEB_HI;
               state_nxt = debounce_hi;
            end
         end

         debounce_hi: begin
            out_nxt = '0;
            tctl.en = 1'b1;
            if (!sync.pulse) begin
               // pulse too short, drop back and clear the timer
               tctl.en   = 1'b0;
               state_nxt = low;
            end
            else if (cnt_zero) begin
               // debounced high, sigout rises and min-high starts
               out_nxt.sigout = 1'b1;
               tctl.ld        = 1'b1;
               load_val       = LD_MIN_HI;
               state_nxt      = hi_no_boost;
            end
         end

         hi_no_boost: begin
            out_nxt.sigout = 1'b1;
            out_nxt.boost  = 1'b0;
            tctl.en        = 1'b1;
            if (sync.boost) begin
               // boost request, time its high debounce
               tctl.ld   = 1'b1;
               load_val  = LD_DEB_HI;
               state_nxt = hi_debounce_boost;
            end
            else if (RESTART_HI_PERIOD && sync.pulse) begin
               // every high sample pushes the min-high period out again
               tctl.ld  = 1'b1;
               load_val = LD_MIN_HI;
            end
            else if (cnt_zero && !sync.pulse) begin
               // min-high done and input low, debounce the fall
               tctl.ld   = 1'b1;
               load_val  = LD_DEB_LO;
               state_nxt = debounce_lo;
            end
         end

         hi_debounce_boost: begin
            out_nxt.sigout = 1'b1;
            out_nxt.boost  = 1'b0;
            tctl.en        = 1'b1;
            if (!sync.boost || !sync.pulse) begin
               // boost spike rejected
               // sigout gets a fresh min-high since the timer was reused
               tctl.ld   = 1'b1;
               load_val  = LD_MIN_HI;
               state_nxt = hi_no_boost;
            end
            else if (cnt_zero) begin
               out_nxt.boost = 1'b1;
               tctl.ld       = 1'b1;
               load_val      = LD_MIN_HI;
               state_nxt     = hi_with_boost;
            end
         end

         hi_with_boost: begin
            out_nxt.sigout = 1'b1;
            out_nxt.boost  = 1'b1;
            tctl.en        = 1'b1;
            // boost held for min-high, then its loss is debounced
            if (cnt_zero && (!sync.boost || !sync.pulse)) begin
               tctl.ld   = 1'b1;
               load_val  = LD_DEB_LO;
               state_nxt = hi_debounce_no_boost;
            end
         end

         hi_debounce_no_boost: begin
            out_nxt.sigout = 1'b1;
            out_nxt.boost  = 1'b1;
            tctl.en        = 1'b1;
            if (sync.boost && sync.pulse) begin
               // both back high, return with the timer already expired
               tctl.ld   = 1'b1;
               load_val  = '0;
               state_nxt = hi_with_boost;
            end
            else if (cnt_zero) begin
               // loss confirmed, timer sits at zero for hi_no_boost
               out_nxt.boost = 1'b0;
               state_nxt     = hi_no_boost;
            end
         end

         debounce_lo: begin
            out_nxt.sigout = 1'b1;
            out_nxt.boost  = 1'b0;
            tctl.en        = 1'b1;
            if (sync.pulse) begin
               // low glitch, back to high
               if (RESTART_HI_PERIOD) begin
                  tctl.ld  = 1'b1;
                  load_val = LD_MIN_HI;
               end
               else begin
                  tctl.en = 1'b0;
               end
               state_nxt = hi_no_boost;
            end
            else if (cnt_zero) begin
               out_nxt.sigout = 1'b0;
               state_nxt      = low;
            end
         end

         default: begin
            out_nxt   = '0;
            state_nxt = low;
         end
      endcase
   end

endmodule

/* hdl/filter_pkg.sv */
// filter package: state encoding, grouped signals and the counter-width helper
package filter_pkg;

   // controller states, three bits wide
   typedef enum logic [2:0] {
      low                  = 3'd0,
      debounce_hi          = 3'd1,
      hi_no_boost          = 3'd2,
      hi_debounce_boost    = 3'd3,
      hi_with_boost        = 3'd4,
      hi_debounce_no_boost = 3'd5,
      debounce_lo          = 3'd6
   } filter_state_t;

   // synchronised copies of the two asynchronous inputs
   typedef struct packed {
      logic pulse;
      logic boost;
   } sync_in_t;

   // registered filter outputs
   // boost is only ever high together with sigout
   typedef struct packed {
      logic sigout;
      logic boost;
   } filter_out_t;

   // period timer commands
   // en low clears the count, ld loads a new period
   typedef struct packed {
      logic en;
      logic ld;
   } timer_ctrl_t;

   // bits needed to hold counts 0 .. max_count
   // never returns less than one bit
   function automatic int cnt_width(input int max_count);
      int w;
      w = 1;
      while ((2 ** w) < (max_count + 1)) begin
         w = w + 1;
      end
      return w;
   endfunction

endpackage

/* hdl/input_sync.sv */
// input synchroniser: two flop stages bring pulse_in and boost_in into the clk domain
`timescale 1ns/1ps

module input_sync (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 pulse_in,
   input  logic                 boost_in,
   output filter_pkg::sync_in_t sync
);
   import filter_pkg::*;

   // first stage, may go metastable
   sync_in_t meta;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meta <= '0;
         sync <= '0;
      end
      else begin
         meta.pulse <= pulse_in;
         meta.boost <= boost_in;
         // second stage settles before the controller samples it
         sync       <= meta;
      end
   end

endmodule

/* hdl/period_timer.sv */
// period timer: loadable saturating down-counter for debounce and minimum-high periods
`timescale 1ns/1ps

module period_timer #(
   parameter int CNT_W = 8
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  filter_pkg::timer_ctrl_t tctl,
   input  logic [CNT_W-1:0]        load_val,
   output logic                    cnt_zero
);

   // remaining cycles of the current period
   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end
      else if (!tctl.en) begin
         // idle, keep the count parked at zero
         cnt <= '0;
      end
      else if (tctl.ld) begin
         cnt <= load_val;
      end
      else if (cnt != '0) begin
         // stops at zero until the next load
         cnt <= cnt - 1'b1;
      end
   end

   // flag for the controller, straight from the count register
   assign cnt_zero = (cnt == '0);

endmodule

/* hdl/pulse_filter_dual.sv */
// dual-level pulse filter top: converts ms periods to clock counts and joins the blocks
`timescale 1ns/1ps

module pulse_filter_dual #(
   parameter int CLK_PERIOD_NS     = 480,
   parameter int DEBOUNCE_HI_MS    = 4,
   parameter int DEBOUNCE_LO_MS    = 4,
   parameter int MIN_HI_MS         = 0,
   parameter bit RESTART_HI_PERIOD = 1'b0
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pulse_in,
   input  logic                    boost_in,
   output filter_pkg::filter_out_t out
);
   import filter_pkg::*;

   // ms to clock counts, 1e6 ns per ms
   localparam int DEBOUNCE_HI_CNT = DEBOUNCE_HI_MS * 1000000 / CLK_PERIOD_NS;
   localparam int DEBOUNCE_LO_CNT = DEBOUNCE_LO_MS * 1000000 / CLK_PERIOD_NS;
   localparam int MIN_HI_CNT      = MIN_HI_MS * 1000000 / CLK_PERIOD_NS;

   // timer sized for the longest period in use
   localparam int DEB_MAX_CNT = (DEBOUNCE_HI_CNT > DEBOUNCE_LO_CNT) ?
                                DEBOUNCE_HI_CNT : DEBOUNCE_LO_CNT;
   localparam int MAX_CNT     = (DEB_MAX_CNT > MIN_HI_CNT) ? DEB_MAX_CNT : MIN_HI_CNT;
   localparam int CNT_W       = cnt_width(MAX_CNT);

   sync_in_t         sync;
   timer_ctrl_t      tctl;
   logic [CNT_W-1:0] load_val;
   logic             cnt_zero;

   input_sync u_input_sync (
      .clk      (clk),
      .rst_n    (rst_n),
      .pulse_in (pulse_in),
      .boost_in (boost_in),
      .sync     (sync)
   );

   filter_fsm #(
      .CNT_W             (CNT_W),
      .DEBOUNCE_HI_CNT   (DEBOUNCE_HI_CNT),
      .DEBOUNCE_LO_CNT   (DEBOUNCE_LO_CNT),
      .MIN_HI_CNT        (MIN_HI_CNT),
      .RESTART_HI_PERIOD (RESTART_HI_PERIOD)
   ) u_filter_fsm (
      .clk      (clk),
      .rst_n    (rst_n),
      .sync     (sync),
      .cnt_zero (cnt_zero),
      .tctl     (tctl),
      .load_val (load_val),
      .out      (out)
   );

   // one timer shared by every period the controller measures
   period_timer #(
      .CNT_W (CNT_W)
   ) u_period_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .tctl     (tctl),
      .load_val (load_val),
      .cnt_zero (cnt_zero)
   );

endmodule

/* pulse_filter_dual.f */
+incdir+tests
hdl/filter_pkg.sv
hdl/input_sync.sv
hdl/period_timer.sv
hdl/filter_fsm.sv
hdl/pulse_filter_dual.sv
tests/tb_pulse_filter.sv

/* tests/tb_stim.svh */
// pulse filter stimulus tasks that change every input on a falling edge
`ifndef TB_STIM_SVH
`define TB_STIM_SVH

// both inputs set on one falling edge and held for the given number of cycles
task automatic drive_for(input logic p, input logic b, input int cycles);
   @(negedge clk);
   pulse_in = p;
   boost_in = b;
   repeat (cycles - 1) @(negedge clk);
endtask

// bounded wait for the debounced fall of sigout
task automatic wait_sigout_low(input int max_cycles);
   int waited;
   waited = 0;
   while (out.sigout && (waited < max_cycles)) begin
      @(negedge clk);
      waited++;
   end
   if (out.sigout) begin
      stop_with_fail("sigout stayed high long after pulse_in went low");
   end
endtask

// random short pulses that are rejected followed by one long pulse that must pass
task automatic reject_short_pulses();
   int w;
   for (int i = 0; i < N_GLITCH; i++) begin
      take_bits(3, w);
      drive_for(1'b1, 1'b0, 1 + w % (DEB_HI_CNT - 3));
      drive_for(1'b0, 1'b0, DEB_HI_CNT);
   end
   drive_for(1'b1, 1'b0, DEB_HI_CNT + 8);
endtask

// input drops soon after the rise and then high stretches with short low glitches
task automatic hold_min_high();
   int w;
   drive_for(1'b0, 1'b0, MIN_HI_CNT - 4);
   for (int i = 0; i < N_GLITCH; i++) begin
      drive_for(1'b1, 1'b0, 6);
      take_bits(3, w);
      drive_for(1'b0, 1'b0, 1 + w % (DEB_LO_CNT - 3));
   end
   drive_for(1'b0, 1'b0, 1);
   wait_sigout_low(FALL_WAIT);
   drive_for(1'b0, 1'b0, 8);
endtask

// short pulses closer than min-high keep restarting the high period
task automatic repeat_short_pulses();
   int w;
   int gap;
   drive_for(1'b1, 1'b0, DEB_HI_CNT + 8);
   for (int i = 0; i < N_GLITCH; i++) begin
      take_bits(2, w);
      take_bits(3, gap);
      drive_for(1'b0, 1'b0, DEB_LO_CNT - 2 + gap % (MIN_HI_CNT - DEB_LO_CNT));
      drive_for(1'b1, 1'b0, 1 + w % 3);
   end
   drive_for(1'b0, 1'b0, 1);
   wait_sigout_low(FALL_WAIT);
   drive_for(1'b0, 1'b0, 8);
endtask

// boost spikes with sigout low and high and then a held boost request
task automatic request_boost();
   int w;
   for (int i = 0; i < N_GLITCH; i++) begin
      take_bits(3, w);
      drive_for(1'b0, 1'b1, 1 + w % (DEB_HI_CNT - 3));
      drive_for(1'b0, 1'b0, DEB_HI_CNT);
   end
   drive_for(1'b1, 1'b0, DEB_HI_CNT + 8);
   for (int i = 0; i < N_GLITCH; i++) begin
      take_bits(3, w);
      drive_for(1'b1, 1'b1, 1 + w % (DEB_HI_CNT - 3));
      drive_for(1'b1, 1'b0, DEB_HI_CNT);
   end
   // boost rises part way through and boost_in drops before pulse_in
   drive_for(1'b1, 1'b1, 3 * DEB_HI_CNT);
   drive_for(1'b1, 1'b0, DEB_HI_CNT);
   drive_for(1'b0, 1'b0, 1);
   wait_sigout_low(FALL_WAIT);
   drive_for(1'b0, 1'b0, 8);
endtask

`endif

/* tests/tb_pulse_filter.sv */
// pulse filter testbench with input-history counters and assertions on sigout and boost timing
`timescale 1ns/1ps

module tb_pulse_filter;
   import filter_pkg::*;

   // 250 us clock period gives 4 counts per ms
   localparam int CLK_PERIOD_NS  = 250000;
   localparam int DEBOUNCE_HI_MS = 2;
   localparam int DEBOUNCE_LO_MS = 2;
   localparam int MIN_HI_MS      = 4;
   localparam int CNT_PER_MS     = 4;

   // the same periods in clock counts
   localparam int DEB_HI_CNT = DEBOUNCE_HI_MS * CNT_PER_MS;
   localparam int DEB_LO_CNT = DEBOUNCE_LO_MS * CNT_PER_MS;
   localparam int MIN_HI_CNT = MIN_HI_MS * CNT_PER_MS;

   localparam int N_GLITCH  = 8;
   localparam int FALL_WAIT = MIN_HI_CNT + 2 * DEB_LO_CNT + 16;
   // time for the boost states to drain back into the plain high path
   localparam int BOOST_SETTLE = MIN_HI_CNT + 2 * DEB_LO_CNT + 8;
   // boost_in never seen counts as a long idle stretch
   localparam int BOOST_IDLE   = 1000;
   // upper bounds of reset, short pulses, min-high, restart and boost scenarios
   localparam int SCEN_CYCLES = 24
      + N_GLITCH * 2 * DEB_HI_CNT + DEB_HI_CNT + 8
      + MIN_HI_CNT + N_GLITCH * (6 + DEB_LO_CNT) + FALL_WAIT + 9
      + DEB_HI_CNT + 8 + N_GLITCH * (3 + MIN_HI_CNT) + FALL_WAIT + 9
      + N_GLITCH * 4 * DEB_HI_CNT + 5 * DEB_HI_CNT + FALL_WAIT + 17;
   localparam int TIMEOUT_CYCLES = 2 * SCEN_CYCLES;

   localparam logic [15:0] LFSR_SEED = 16'd11861;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   logic        clk;
   logic        rst_n;
   logic        pulse_in;
   logic        boost_in;
   filter_out_t out;

   logic [15:0] lfsr;
   int          cycle_cnt;

   // run lengths of the inputs and outputs counted on rising edges
   int   hi_run;
   int   last_hi_run;
   int   lo_run;
   int   both_run;
   int   last_both_run;
   int   boost_lo_run;
   int   sig_hi_len;
   int   boost_hi_len;
   logic boost_settled;

   pulse_filter_dual #(
      .CLK_PERIOD_NS     (CLK_PERIOD_NS),
      .DEBOUNCE_HI_MS    (DEBOUNCE_HI_MS),
      .DEBOUNCE_LO_MS    (DEBOUNCE_LO_MS),
      .MIN_HI_MS         (MIN_HI_MS),
      .RESTART_HI_PERIOD (1'b1)
   ) UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .pulse_in (pulse_in),
      .boost_in (boost_in),
      .out      (out)
   );

   task automatic stop_with_fail(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic mismatch(input string what);
      stop_with_fail($sformatf("Mismatch at %0t ns: %s", $time, what));
   endtask

   // galois form with right shift and feedback from bit 0
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ LFSR_TAPS;
      end
      return state >> 1;
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int nbits, output int value);
      value = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr  = lfsr_step(lfsr);
         value = (value << 1) | lfsr[0];
      end
   endtask

   `include "tb_stim.svh"

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hi_run        <= 0;
         last_hi_run   <= 0;
         lo_run        <= 0;
         both_run      <= 0;
         last_both_run <= 0;
         boost_lo_run  <= BOOST_IDLE;
         sig_hi_len    <= 0;
         boost_hi_len  <= 0;
      end
      else begin
         hi_run        <= pulse_in ? hi_run + 1 : 0;
         // length of the latest high run kept after it ends
         last_hi_run   <= pulse_in ? hi_run + 1 : last_hi_run;
         lo_run        <= pulse_in ? 0 : lo_run + 1;
         both_run      <= (pulse_in && boost_in) ? both_run + 1 : 0;
         last_both_run <= (pulse_in && boost_in) ? both_run + 1 : last_both_run;
         boost_lo_run  <= boost_in ? 0 : boost_lo_run + 1;
         sig_hi_len    <= out.sigout ? sig_hi_len + 1 : 0;
         boost_hi_len  <= out.boost ? boost_hi_len + 1 : 0;
      end
   end

   // boost_in gone well before the last pulse so only the plain high path applies
   assign boost_settled = (boost_lo_run > lo_run + BOOST_SETTLE);

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_fail("Timeout: the run did not finish within the cycle limit");
      end
   end

   a_reset: assert property (@(posedge clk) !rst_n |-> (out == '0))
      else mismatch("outputs not cleared during reset");
   a_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (last_hi_run == 0) |-> !out.sigout)
      else mismatch("sigout high with no pulse since reset");
   a_short: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out.sigout) |-> (last_hi_run >= DEB_HI_CNT))
      else mismatch("sigout rose on a pulse shorter than the high debounce");
   a_rise: assert property (@(posedge clk) disable iff (!rst_n)
      (hi_run >= DEB_HI_CNT + 6) |-> out.sigout)
      else mismatch("sigout late after a held pulse");
   a_min_hi: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(out.sigout) |-> (sig_hi_len >= MIN_HI_CNT))
      else mismatch("sigout high for less than the minimum period");
   // with restart every high sample pushes the fall out by min-high plus low debounce
   a_lo_deb: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(out.sigout) |->
      (lo_run >= (boost_settled ? MIN_HI_CNT + DEB_LO_CNT : DEB_LO_CNT)))
      else mismatch("sigout fell too soon after the last high sample");
   a_fall: assert property (@(posedge clk) disable iff (!rst_n)
      (boost_settled && (lo_run > MIN_HI_CNT + DEB_LO_CNT + 4)) |-> !out.sigout)
      else mismatch("sigout still high long after pulse_in went low");
   a_gate: assert property (@(posedge clk) disable iff (!rst_n)
      out.boost |-> out.sigout)
      else mismatch("boost high while sigout low");
   a_spike: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out.boost) |-> (last_both_run >= DEB_HI_CNT))
      else mismatch("boost rose on a spike shorter than the high debounce");
   // only once sigout was already high when both inputs rose
   a_boost_rise: assert property (@(posedge clk) disable iff (!rst_n)
      ((both_run >= DEB_HI_CNT + 6) && (sig_hi_len >= both_run)) |-> out.boost)
      else mismatch("boost late with boost_in and pulse_in held high");
   a_boost_min: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(out.boost) |-> (boost_hi_len >= MIN_HI_CNT))
      else mismatch("boost high for less than the minimum period");

   initial begin
      pulse_in  = 1'b0;
      boost_in  = 1'b0;
      rst_n     = 1'b1;
      lfsr      = LFSR_SEED;
      cycle_cnt = 0;
      #1 rst_n = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      drive_for(1'b0, 1'b0, 8);
      reject_short_pulses();
      hold_min_high();
      repeat_short_pulses();
      request_boost();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
